//--- backing_memory.sv
module backing_memory (
	input  logic       clk,
	input  logic       rst,
	mem_port_if.memory mem
);

	logic [cache_geom_pkg::LINE_W-1:0]     store [2**cache_geom_pkg::LINE_ADDR_W];
	logic [cache_geom_pkg::LINE_W-1:0]     rd_data_q;
	logic                                  busy;
	logic [cache_ctrl_pkg::LAT_CNT_W-1:0]  cnt;
	logic                                  start;

	// power-up contents, each word is its address xor a constant
	initial begin
		int unsigned waddr;
		for (int l = 0; l < 2**cache_geom_pkg::LINE_ADDR_W; l++) begin
			for (int w = 0; w < cache_geom_pkg::LINE_WORDS; w++) begin
				waddr = l * cache_geom_pkg::LINE_WORDS + w;
				store[l][w*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] =
					waddr[cache_geom_pkg::WORD_W-1:0] ^ cache_ctrl_pkg::MEM_INIT_XOR;
			end
		end
	end

	assign start         = (mem.m_re || mem.m_we) && !busy;
	assign mem.m_rdy     = !busy;
	assign mem.m_rd_data = rd_data_q;

	// writes land at the start of the access, reads are captured there too
	always @(posedge clk) begin
		if (start && mem.m_we) begin
			store[mem.m_addr] <= mem.m_wr_data;
		end
		if (start && mem.m_re) begin
			rd_data_q <= store[mem.m_addr];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// latency counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= cache_ctrl_pkg::LAT_LOAD;
		end else if (busy) begin
			if (cnt == '0) begin
				busy <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

//--- cache.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
mem_port_if.sv
line_array.sv
cache_lookup.sv
miss_controller.sv
backing_memory.sv
cache.sv
tb_clock_gen.sv
cache_assertions.sv
cache_tb.sv

//--- cache.sv
module cache (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   i_addr,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   i_d_addr,
	input  logic                                i_re,
	input  logic                                i_we,
	input  logic [cache_geom_pkg::WORD_W-1:0]   i_wrt_data,
	output logic [cache_geom_pkg::WORD_W-1:0]   o_instr,
	output logic [cache_geom_pkg::WORD_W-1:0]   o_d_data,
	output logic                                o_ready
);

	logic                    i_hit;
	logic                    d_hit;
	logic                    d_hit_way;
	logic                    lru;
	logic                    i_we_line;
	logic                    d_we_line;
	logic                    d_way;
	logic                    lru_we;
	logic                    lru_val;
	cache_geom_pkg::i_line_t i_line;
	cache_geom_pkg::i_line_t i_wr_line;
	cache_geom_pkg::d_line_t d_line0;
	cache_geom_pkg::d_line_t d_line1;
	cache_geom_pkg::d_line_t d_wr_line;

	mem_port_if mem_bus ();

	// tag and data lookup
	cache_lookup u_lookup (
		.clk         (clk),
		.rst         (rst),
		.i_addr      (i_addr),
		.i_d_addr    (i_d_addr),
		.i_i_we      (i_we_line),
		.i_i_wr_line (i_wr_line),
		.i_d_we      (d_we_line),
		.i_d_way     (d_way),
		.i_d_wr_line (d_wr_line),
		.i_lru_we    (lru_we),
		.i_lru_val   (lru_val),
		.o_i_hit     (i_hit),
		.o_i_line    (i_line),
		.o_d_hit     (d_hit),
		.o_d_hit_way (d_hit_way),
		.o_d_line0   (d_line0),
		.o_d_line1   (d_line1),
		.o_lru       (lru),
		.o_instr     (o_instr),
		.o_d_data    (o_d_data)
	);

	// refill and write-back sequencing
	miss_controller u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.i_addr      (i_addr),
		.i_d_addr    (i_d_addr),
		.i_re        (i_re),
		.i_we        (i_we),
		.i_wrt_data  (i_wrt_data),
		.i_i_hit     (i_hit),
		.i_i_line    (i_line),
		.i_d_hit     (d_hit),
		.i_d_hit_way (d_hit_way),
		.i_d_line0   (d_line0),
		.i_d_line1   (d_line1),
		.i_lru       (lru),
		.o_i_we      (i_we_line),
		.o_i_wr_line (i_wr_line),
		.o_d_we      (d_we_line),
		.o_d_way     (d_way),
		.o_d_wr_line (d_wr_line),
		.o_lru_we    (lru_we),
		.o_lru_val   (lru_val),
		.o_ready     (o_ready),
		.mem         (mem_bus.ctrl)
	);

	backing_memory u_mem (
		.clk (clk),
		.rst (rst),
		.mem (mem_bus.memory)
	);

endmodule

//--- cache_assertions.sv
module cache_assertions (
	input logic                                   clk,
	input logic                                   rst,
	input cache_ctrl_pkg::ctrl_state_t            state,
	input logic                                   o_ready,
	input logic                                   m_re,
	input logic                                   m_we,
	input logic                                   m_rdy,
	input logic [cache_geom_pkg::LINE_ADDR_W-1:0] m_addr
);

	int fail_cnt = 0;

	// one strobe at a time on the memory port
	a_strobe_excl: assert property (@(posedge clk) disable iff (rst) !(m_re && m_we))
		else begin
			$error("memory read and write strobes high in the same cycle");
			fail_cnt = fail_cnt + 1;
		end

	// a busy memory means a miss is being served, so never idle or ready
	a_busy_miss: assert property (@(posedge clk) disable iff (rst)
		!m_rdy |-> (state != cache_ctrl_pkg::IDLE && !o_ready))
		else begin
			$error("memory busy while the controller is idle or ready");
			fail_cnt = fail_cnt + 1;
		end

	// strobe and address held while the memory is busy
	a_strobe_hold: assert property (@(posedge clk) disable iff (rst)
		(!m_rdy && $past(m_re || m_we)) |->
		(m_re == $past(m_re) && m_we == $past(m_we) && m_addr == $past(m_addr)))
		else begin
			$error("memory strobe or address changed while m_rdy low");
			fail_cnt = fail_cnt + 1;
		end

endmodule

bind miss_controller cache_assertions u_assert (
	.clk     (clk),
	.rst     (rst),
	.state   (state),
	.o_ready (o_ready),
	.m_re    (mem.m_re),
	.m_we    (mem.m_we),
	.m_rdy   (mem.m_rdy),
	.m_addr  (mem.m_addr)
);

//--- cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// miss controller states
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		IFETCH     = 3'd1,
		DFETCH     = 3'd2,
		DWRITEBACK = 3'd3
	} ctrl_state_t;

	// busy cycles per memory access
	localparam int MEM_LATENCY = 4;
	localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);
	localparam logic [LAT_CNT_W-1:0] LAT_LOAD = LAT_CNT_W'(MEM_LATENCY - 1);

	// power-up pattern, word address xor this
	localparam logic [15:0] MEM_INIT_XOR = 16'hA5C3;

endpackage

//--- cache_geom_pkg.sv
package cache_geom_pkg;

	// address and word sizes
	localparam int ADDR_W      = 16;
	localparam int WORD_W      = 16;
	localparam int LINE_WORDS  = 4;
	localparam int OFFSET_W    = $clog2(LINE_WORDS);
	localparam int LINE_W      = LINE_WORDS * WORD_W;
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	// instruction cache, direct mapped
	localparam int I_INDEX_W = 6;
	localparam int I_TAG_W   = ADDR_W - I_INDEX_W - OFFSET_W;

	// data cache, two ways
	localparam int D_INDEX_W = 5;
	localparam int D_TAG_W   = ADDR_W - D_INDEX_W - OFFSET_W;
	localparam int D_WAYS    = 2;

	//////////////////////////////////////////////////////////////////////
	// line layouts, word 0 sits in the low bits
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                                   valid;
		logic [I_TAG_W-1:0]                     tag;
		logic [LINE_WORDS-1:0][WORD_W-1:0]      data;
	} i_line_t;

	typedef struct packed {
		logic                                   valid;
		logic                                   dirty;
		logic [D_TAG_W-1:0]                     tag;
		logic [LINE_WORDS-1:0][WORD_W-1:0]      data;
	} d_line_t;

endpackage

//--- cache_lookup.sv
module cache_lookup (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   i_addr,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   i_d_addr,
	// instruction line write
	input  logic                                i_i_we,
	input  cache_geom_pkg::i_line_t             i_i_wr_line,
	// data line write
	input  logic                                i_d_we,
	input  logic                                i_d_way,
	input  cache_geom_pkg::d_line_t             i_d_wr_line,
	// lru update
	input  logic                                i_lru_we,
	input  logic                                i_lru_val,
	output logic                                o_i_hit,
	output cache_geom_pkg::i_line_t             o_i_line,
	output logic                                o_d_hit,
	output logic                                o_d_hit_way,
	output cache_geom_pkg::d_line_t             o_d_line0,
	output cache_geom_pkg::d_line_t             o_d_line1,
	output logic                                o_lru,
	output logic [cache_geom_pkg::WORD_W-1:0]   o_instr,
	output logic [cache_geom_pkg::WORD_W-1:0]   o_d_data
);

	logic [cache_geom_pkg::I_INDEX_W-1:0] i_index;
	logic [cache_geom_pkg::I_TAG_W-1:0]   i_tag;
	logic [cache_geom_pkg::D_INDEX_W-1:0] d_index;
	logic [cache_geom_pkg::D_TAG_W-1:0]   d_tag;
	logic [cache_geom_pkg::D_WAYS-1:0]    d_way_hit;
	logic [2**cache_geom_pkg::D_INDEX_W-1:0] lru;

	cache_geom_pkg::d_line_t d_rd [cache_geom_pkg::D_WAYS];

	// address fields
	assign i_index = i_addr[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::I_INDEX_W];
	assign i_tag   = i_addr[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::I_TAG_W];
	assign d_index = i_d_addr[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::D_INDEX_W];
	assign d_tag   = i_d_addr[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::D_TAG_W];

	//////////////////////////////////////////////////////////////////////
	// instruction side
	//////////////////////////////////////////////////////////////////////

	line_array #(
		.line_t  (cache_geom_pkg::i_line_t),
		.INDEX_W (cache_geom_pkg::I_INDEX_W)
	) u_i_lines (
		.clk       (clk),
		.rst       (rst),
		.i_index   (i_index),
		.i_we      (i_i_we),
		.i_wr_line (i_i_wr_line),
		.o_rd_line (o_i_line)
	);

	assign o_i_hit = o_i_line.valid && (o_i_line.tag == i_tag);
	assign o_instr = o_i_line.data[i_addr[cache_geom_pkg::OFFSET_W-1:0]];

	//////////////////////////////////////////////////////////////////////
	// data side, one array per way
	//////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w < cache_geom_pkg::D_WAYS; w++) begin : g_way
		line_array #(
			.line_t  (cache_geom_pkg::d_line_t),
			.INDEX_W (cache_geom_pkg::D_INDEX_W)
		) u_d_lines (
			.clk       (clk),
			.rst       (rst),
			.i_index   (d_index),
			.i_we      (i_d_we && (int'(i_d_way) == w)),
			.i_wr_line (i_d_wr_line),
			.o_rd_line (d_rd[w])
		);

		assign d_way_hit[w] = d_rd[w].valid && (d_rd[w].tag == d_tag);
	end

	assign o_d_line0   = d_rd[0];
	assign o_d_line1   = d_rd[1];
	assign o_d_hit     = |d_way_hit;
	// way 0 wins if both match, which cannot happen after a clean refill
	assign o_d_hit_way = ~d_way_hit[0];
	assign o_d_data    = d_rd[o_d_hit_way].data[i_d_addr[cache_geom_pkg::OFFSET_W-1:0]];

	// lru bit holds the most recently used way of each set
	always_ff @(posedge clk) begin
		if (rst) begin
			lru <= '0;
		end else if (i_lru_we) begin
			lru[d_index] <= i_lru_val;
		end
	end

	assign o_lru = lru[d_index];

endmodule

//--- cache_tb.sv
module cache_tb;

	localparam logic [1:0] OP_NONE = 2'd0;
	localparam logic [1:0] OP_RD   = 2'd1;
	localparam logic [1:0] OP_WR   = 2'd2;
	localparam int         READY_TIMEOUT = 40;

	logic        clk;
	logic        rst;
	logic [15:0] i_addr;
	logic [15:0] i_d_addr;
	logic        i_re;
	logic        i_we;
	logic [15:0] i_wrt_data;
	logic [15:0] o_instr;
	logic [15:0] o_d_data;
	logic        o_ready;

	// stimulus table, one entry per row in each queue
	logic [15:0] ia_q [$];
	logic [15:0] da_q [$];
	logic [1:0]  op_q [$];
	logic [15:0] wd_q [$];
	logic        hit_q [$];
	string       name_q [$];

	// expected memory contents, word addressed
	logic [15:0] ref_mem [65536];

	tb_clock_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	cache dut (
		.clk        (clk),
		.rst        (rst),
		.i_addr     (i_addr),
		.i_d_addr   (i_d_addr),
		.i_re       (i_re),
		.i_we       (i_we),
		.i_wrt_data (i_wrt_data),
		.o_instr    (o_instr),
		.o_d_data   (o_d_data),
		.o_ready    (o_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// hit = 1 means the row must finish with no stall
	task automatic add_row(input logic [15:0] ia, input logic [15:0] da, input logic [1:0] op,
		input logic [15:0] wd, input logic hit, input string name);
		ia_q.push_back(ia);
		da_q.push_back(da);
		op_q.push_back(op);
		wd_q.push_back(wd);
		hit_q.push_back(hit);
		name_q.push_back(name);
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	// counts the rising edges spent with o_ready low
	task automatic wait_ready(input string name, output int stalls);
		stalls = 0;
		@(posedge clk);
		while (!o_ready) begin
			stalls++;
			if (stalls >= READY_TIMEOUT) begin
				$display("timeout: o_ready stayed low for %0d cycles in %s", stalls, name);
				$display("ERRORS FOUND");
				$fatal(1, "o_ready timeout");
			end
			@(posedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rnd;
		int          stalls;
		int          rcnt;

		i_addr     = '0;
		i_d_addr   = '0;
		i_re       = 1'b0;
		i_we       = 1'b0;
		i_wrt_data = '0;

		for (int a = 0; a < 65536; a++) begin
			ref_mem[a] = a[15:0] ^ cache_ctrl_pkg::MEM_INIT_XOR;
		end

		// code lives below 0x0100, data from 0x1000 up
		add_row(16'h0010, 16'h1000, OP_NONE, 16'h0000, 1'b0, "ifetch_miss");
		add_row(16'h0011, 16'h1000, OP_NONE, 16'h0000, 1'b1, "ifetch_word1");
		add_row(16'h0013, 16'h1000, OP_NONE, 16'h0000, 1'b1, "ifetch_word3");
		add_row(16'h0012, 16'h1000, OP_NONE, 16'h0000, 1'b1, "ifetch_word2");
		add_row(16'h0040, 16'h1000, OP_NONE, 16'h0000, 1'b0, "ifetch_other_line");
		add_row(16'h0010, 16'h1004, OP_RD,   16'h0000, 1'b0, "dread_miss");
		add_row(16'h0010, 16'h1005, OP_RD,   16'h0000, 1'b1, "dread_word1");
		add_row(16'h0010, 16'h1006, OP_RD,   16'h0000, 1'b1, "dread_word2");
		add_row(16'h0010, 16'h1007, OP_RD,   16'h0000, 1'b1, "dread_word3");
		add_row(16'h0010, 16'h1008, OP_WR,   16'hBEEF, 1'b0, "dwrite_miss");
		add_row(16'h0010, 16'h1008, OP_RD,   16'h0000, 1'b1, "dread_written");
		add_row(16'h0010, 16'h1009, OP_RD,   16'h0000, 1'b1, "dread_neighbour");
		// set 0 gets three tags
		add_row(16'h0020, 16'h1000, OP_RD,   16'h0000, 1'b0, "set0_fill_a");
		add_row(16'h0020, 16'h1080, OP_RD,   16'h0000, 1'b0, "set0_fill_b");
		add_row(16'h0020, 16'h1001, OP_RD,   16'h0000, 1'b1, "set0_touch_a");
		add_row(16'h0020, 16'h1100, OP_RD,   16'h0000, 1'b0, "set0_evict_b");
		add_row(16'h0020, 16'h1002, OP_RD,   16'h0000, 1'b1, "set0_a_kept");
		// dirty line pushed out, then read back
		add_row(16'h0030, 16'h1180, OP_WR,   16'h1234, 1'b0, "dirty_write");
		add_row(16'h0030, 16'h1200, OP_RD,   16'h0000, 1'b0, "dirty_evict_a");
		add_row(16'h0030, 16'h1280, OP_RD,   16'h0000, 1'b0, "dirty_writeback");
		add_row(16'h0030, 16'h1180, OP_RD,   16'h0000, 1'b0, "dirty_read_back");

		rnd = 32'd99;
		for (int k = 0; k < 24; k++) begin
			rnd = next_random(rnd);
			add_row({8'h00, rnd[7:0]}, 16'h1000 | {7'b0, rnd[16:8]},
				rnd[17] ? OP_WR : OP_RD, rnd[31:16], 1'b0, $sformatf("random_%0d", k));
		end

		@(negedge clk);
		rcnt = 0;
		while (rst) begin
			@(posedge clk);
			rcnt++;
			if (rcnt > 10) begin
				$display("reset was never released");
				$display("ERRORS FOUND");
				$fatal(1, "reset timeout");
			end
		end

		// the FSM first fetches the line at address 0, inputs held until done
		wait_ready("reset", stalls);

		for (int i = 0; i < name_q.size(); i++) begin
			@(negedge clk);
			i_addr     = ia_q[i];
			i_d_addr   = da_q[i];
			i_re       = (op_q[i] == OP_RD);
			i_we       = (op_q[i] == OP_WR);
			i_wrt_data = wd_q[i];
			wait_ready(name_q[i], stalls);

			check_value({name_q[i], " instr"}, ref_mem[ia_q[i]], o_instr);
			if (op_q[i] == OP_RD) begin
				check_value({name_q[i], " data"}, ref_mem[da_q[i]], o_d_data);
			end
			if (hit_q[i]) begin
				check_value({name_q[i], " stall cycles"}, 16'd0, stalls[15:0]);
			end
			// write lands at this edge
			if (op_q[i] == OP_WR) begin
				ref_mem[da_q[i]] = wd_q[i];
			end
		end

		@(negedge clk);
		i_re = 1'b0;
		i_we = 1'b0;
		@(negedge clk);

		if (dut.u_ctrl.u_assert.fail_cnt == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "assertion failures");
		end
	end

endmodule

//--- line_array.sv
module line_array #(
	parameter type line_t  = logic,
	parameter int  INDEX_W = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic [INDEX_W-1:0] i_index,
	input  logic               i_we,
	input  line_t              i_wr_line,
	output line_t              o_rd_line
);

	line_t lines [2**INDEX_W];

	// lookup is combinational, tags compared in the same cycle
	assign o_rd_line = lines[i_index];

	// reset wipes every line so valid bits start cleared
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**INDEX_W; i++) begin
				lines[i] <= '0;
			end
		end else if (i_we) begin
			lines[i_index] <= i_wr_line;
		end
	end

endmodule

//--- mem_port_if.sv
interface mem_port_if;

	// controller side
	logic                                    m_re;
	logic                                    m_we;
	logic [cache_geom_pkg::LINE_ADDR_W-1:0]  m_addr;
	logic [cache_geom_pkg::LINE_W-1:0]       m_wr_data;

	// memory side
	logic [cache_geom_pkg::LINE_W-1:0]       m_rd_data;
	logic                                    m_rdy;

	modport ctrl (
		output m_re, m_we, m_addr, m_wr_data,
		input  m_rd_data, m_rdy
	);

	modport memory (
		input  m_re, m_we, m_addr, m_wr_data,
		output m_rd_data, m_rdy
	);

	modport monitor (
		input m_re, m_we, m_addr, m_wr_data, m_rd_data, m_rdy
	);

endinterface

//--- miss_controller.sv
module miss_controller (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   i_addr,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   i_d_addr,
	input  logic                                i_re,
	input  logic                                i_we,
	input  logic [cache_geom_pkg::WORD_W-1:0]   i_wrt_data,
	// lookup results
	input  logic                                i_i_hit,
	input  cache_geom_pkg::i_line_t             i_i_line,
	input  logic                                i_d_hit,
	input  logic                                i_d_hit_way,
	input  cache_geom_pkg::d_line_t             i_d_line0,
	input  cache_geom_pkg::d_line_t             i_d_line1,
	input  logic                                i_lru,
	// lookup writes
	output logic                                o_i_we,
	output cache_geom_pkg::i_line_t             o_i_wr_line,
	output logic                                o_d_we,
	output logic                                o_d_way,
	output cache_geom_pkg::d_line_t             o_d_wr_line,
	output logic                                o_lru_we,
	output logic                                o_lru_val,
	output logic                                o_ready,
	mem_port_if.ctrl                            mem
);

	cache_ctrl_pkg::ctrl_state_t state;
	cache_ctrl_pkg::ctrl_state_t next_state;

	logic                                    d_req;
	logic                                    victim_way;
	logic                                    victim_dirty;
	cache_geom_pkg::d_line_t                 victim_line;
	cache_geom_pkg::d_line_t                 hit_line;
	logic [cache_geom_pkg::LINE_ADDR_W-1:0]  i_line_addr;
	logic [cache_geom_pkg::LINE_ADDR_W-1:0]  d_line_addr;
	logic [cache_geom_pkg::LINE_ADDR_W-1:0]  victim_addr;
	logic [cache_geom_pkg::OFFSET_W-1:0]     d_word;

	assign d_req       = i_re || i_we;
	assign i_line_addr = i_addr[cache_geom_pkg::ADDR_W-1:cache_geom_pkg::OFFSET_W];
	assign d_line_addr = i_d_addr[cache_geom_pkg::ADDR_W-1:cache_geom_pkg::OFFSET_W];
	assign d_word      = i_d_addr[cache_geom_pkg::OFFSET_W-1:0];
	assign hit_line    = i_d_hit_way ? i_d_line1 : i_d_line0;

	// empty way first, otherwise the one not used last
	assign victim_way   = !i_d_line0.valid ? 1'b0 :
	                      !i_d_line1.valid ? 1'b1 : ~i_lru;
	assign victim_line  = victim_way ? i_d_line1 : i_d_line0;
	assign victim_dirty = victim_line.valid && victim_line.dirty;
	assign victim_addr  = {victim_line.tag,
		i_d_addr[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::D_INDEX_W]};

	// ready only when nothing is outstanding
	assign o_ready = (state == cache_ctrl_pkg::IDLE) && i_i_hit && (!d_req || i_d_hit);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_ctrl_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and strobes
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state    = state;
		o_i_we        = 1'b0;
		o_i_wr_line   = i_i_line;
		o_d_we        = 1'b0;
		o_d_way       = victim_way;
		o_d_wr_line   = victim_line;
		o_lru_we      = 1'b0;
		o_lru_val     = victim_way;
		mem.m_re      = 1'b0;
		mem.m_we      = 1'b0;
		mem.m_addr    = i_line_addr;
		mem.m_wr_data = victim_line.data;

		case (state)
			cache_ctrl_pkg::IDLE: begin
				if (!i_i_hit) begin
					// instruction miss goes first
					mem.m_re   = 1'b1;
					next_state = cache_ctrl_pkg::IFETCH;
				end else if (d_req) begin
					if (i_d_hit) begin
						o_lru_we  = 1'b1;
						o_lru_val = i_d_hit_way;
						if (i_we) begin
							// merge the word and mark dirty
							o_d_we                   = 1'b1;
							o_d_way                  = i_d_hit_way;
							o_d_wr_line              = hit_line;
							o_d_wr_line.dirty        = 1'b1;
							o_d_wr_line.data[d_word] = i_wrt_data;
						end
					end else if (victim_dirty) begin
						mem.m_we   = 1'b1;
						mem.m_addr = victim_addr;
						next_state = cache_ctrl_pkg::DWRITEBACK;
					end else begin
						mem.m_re   = 1'b1;
						mem.m_addr = d_line_addr;
						next_state = cache_ctrl_pkg::DFETCH;
					end
				end
			end

			cache_ctrl_pkg::IFETCH: begin
				if (!mem.m_rdy) begin
					mem.m_re = 1'b1;
				end else begin
					o_i_we            = 1'b1;
					o_i_wr_line.valid = 1'b1;
					o_i_wr_line.tag   = i_addr[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::I_TAG_W];
					o_i_wr_line.data  = mem.m_rd_data;
					next_state        = cache_ctrl_pkg::IDLE;
				end
			end

			cache_ctrl_pkg::DWRITEBACK: begin
				if (!mem.m_rdy) begin
					mem.m_we   = 1'b1;
					mem.m_addr = victim_addr;
				end else begin
					// victim is out, start the refill right away
					mem.m_re   = 1'b1;
					mem.m_addr = d_line_addr;
					next_state = cache_ctrl_pkg::DFETCH;
				end
			end

			cache_ctrl_pkg::DFETCH: begin
				mem.m_addr = d_line_addr;
				if (!mem.m_rdy) begin
					mem.m_re = 1'b1;
				end else begin
					o_d_we            = 1'b1;
					o_d_wr_line.valid = 1'b1;
					o_d_wr_line.dirty = 1'b0;
					o_d_wr_line.tag   = i_d_addr[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::D_TAG_W];
					o_d_wr_line.data  = mem.m_rd_data;
					// filled way becomes most recent
					o_lru_we          = 1'b1;
					next_state        = cache_ctrl_pkg::IDLE;
				end
			end

			default: begin
				next_state = cache_ctrl_pkg::IDLE;
			end
		endcase
	end

endmodule

//--- run.sh
#!/bin/sh
# builds and runs the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
	-f cache.f -o cache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/cache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	exit 0
else
	exit 1
fi

//--- tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// 20 unit period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held for three rising edges
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule
